// ==== tcpcPkg.sv ====
package tcpcPkg;

	typedef logic [7:0]  regAddr_t;
	typedef logic [15:0] regData_t;
	typedef logic [7:0]  regByte_t;

	// host request as seen on the bus
	typedef struct packed {
		regAddr_t addr;
		regData_t wrData;
		logic     readNotWrite;
	} busReq_t;

	typedef enum logic [4:0] {
		selVendorId, selProductId, selDeviceId,
		selTypecRev, selPdRev, selPdIfRev,
		selAlert, selAlertMask,
		selPowerStatusMask, selFaultStatusMask,
		selCtrl,
		selCcStatus, selPowerStatus, selFaultStatus,
		selTransmit, selTxByteCount, selTxBuf,
		selVbusThresh,
		selNone
	} regSel_t;

	typedef struct packed {
		regSel_t    sel;
		logic [4:0] index;  // ctrl reg, tx byte or vbus word number
		logic       wrEn;
		regData_t   wrData;
	} decodedReq_t;

	typedef struct packed {
		regByte_t ccStatus;
		regByte_t powerStatus;
	} portStatus_t;

	localparam int ctrlCount  = 5;
	localparam int txBufBytes = 30;  // header plus seven objects
	localparam int vbusWords  = 4;

	localparam regAddr_t addrVendorId        = 8'h00;
	localparam regAddr_t addrProductId       = 8'h02;
	localparam regAddr_t addrDeviceId        = 8'h04;
	localparam regAddr_t addrTypecRev        = 8'h06;
	localparam regAddr_t addrPdRev           = 8'h08;
	localparam regAddr_t addrPdIfRev         = 8'h0A;
	localparam regAddr_t addrAlert           = 8'h10;
	localparam regAddr_t addrAlertMask       = 8'h12;
	localparam regAddr_t addrPowerStatusMask = 8'h14;
	localparam regAddr_t addrFaultStatusMask = 8'h15;
	localparam regAddr_t addrCtrlBase        = 8'h18;  // 0x18..0x1C
	localparam regAddr_t addrCcStatus        = 8'h1D;
	localparam regAddr_t addrPowerStatus     = 8'h1E;
	localparam regAddr_t addrFaultStatus     = 8'h1F;
	localparam regAddr_t addrTransmit        = 8'h50;
	localparam regAddr_t addrTxByteCount     = 8'h51;
	localparam regAddr_t addrTxBufBase       = 8'h52;  // 0x52..0x6F
	localparam regAddr_t addrVbusBase        = 8'h72;  // 16-bit words up to 0x78

	localparam regData_t typecRevValue = 16'h0016;
	localparam regData_t pdRevValue    = 16'h0000;
	localparam regData_t pdIfRevValue  = 16'hABCD;

	localparam regData_t alertMaskReset   = 16'h0FFF;
	localparam regByte_t statusMaskReset  = 8'hFF;
	localparam regByte_t faultStatusReset = 8'h80;
	localparam regByte_t txByteCountReset = 8'h65;

	// std output config, tcpc ctrl, role ctrl, fault ctrl, power ctrl
	localparam regByte_t ctrlReset [ctrlCount] = '{8'h60, 8'h00, 8'h0A, 8'h00, 8'h60};

	localparam regByte_t txBufReset [txBufBytes] = '{
		8'h63, 8'h38, 8'h67, 8'h37, 8'h32, 8'hFF, 8'hC7, 8'hA7, 8'hA2, 8'hF9,
		8'h54, 8'h35, 8'h46, 8'h67, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
	};

endpackage

// ==== tcpcBusFront.sv ====
module tcpcBusFront import tcpcPkg::*;
(
	input  logic     CLK,
	input  logic     reset,
	input  logic     req_i,
	input  busReq_t  request_i,
	input  logic     storeDone_i,
	input  regData_t storeData_i,
	output logic     ack_o,
	output regData_t rdData_o,
	output logic     frontValid_o,
	output busReq_t  frontReq_o
);

	typedef enum logic [1:0] {frontIdle, frontWait, frontAck} frontState_t;

	frontState_t state;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state        <= frontIdle;
			frontValid_o <= 1'b0;
		end
		else
		begin
			frontValid_o <= 1'b0;  // single cycle pulse
			case (state)
				frontIdle:
				begin
					if (req_i)
					begin
						frontValid_o <= 1'b1;
						state        <= frontWait;
					end
				end
				frontWait:
				begin
					if (storeDone_i)
						state <= frontAck;
				end
				frontAck:
				begin
					if (!req_i)  // host done, release ack
						state <= frontIdle;
				end
				default:
					state <= frontIdle;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == frontIdle && req_i)
			frontReq_o <= request_i;  // stable while req is high
		if (state == frontWait && storeDone_i)
			rdData_o <= storeData_i;  // held through the ack phase
	end

	assign ack_o = (state == frontAck);

endmodule

// ==== tcpcAddrDecode.sv ====
module tcpcAddrDecode import tcpcPkg::*;
(
	input  logic        CLK,
	input  logic        reset,
	input  logic        frontValid_i,
	input  busReq_t     frontReq_i,
	output logic        decodeValid_o,
	output decodedReq_t decodeReq_o
);

	regAddr_t   addr;
	regAddr_t   ctrlOff;
	regAddr_t   txOff;
	regAddr_t   vbusOff;
	regSel_t    sel;
	logic [4:0] index;
	logic       writable;
	logic       isWrite;

	assign addr    = frontReq_i.addr;
	assign ctrlOff = addr - addrCtrlBase;  // wraps high below the base
	assign txOff   = addr - addrTxBufBase;
	assign vbusOff = addr - addrVbusBase;
	assign isWrite = !frontReq_i.readNotWrite;

	always_comb
	begin
		sel   = selNone;
		index = '0;
		case (addr)
			addrVendorId:        sel = selVendorId;
			addrProductId:       sel = selProductId;
			addrDeviceId:        sel = selDeviceId;
			addrTypecRev:        sel = selTypecRev;
			addrPdRev:           sel = selPdRev;
			addrPdIfRev:         sel = selPdIfRev;
			addrAlert:           sel = selAlert;
			addrAlertMask:       sel = selAlertMask;
			addrPowerStatusMask: sel = selPowerStatusMask;
			addrFaultStatusMask: sel = selFaultStatusMask;
			addrCcStatus:        sel = selCcStatus;
			addrPowerStatus:     sel = selPowerStatus;
			addrFaultStatus:     sel = selFaultStatus;
			addrTransmit:        sel = selTransmit;
			addrTxByteCount:     sel = selTxByteCount;
			default:
			begin
				if (ctrlOff < regAddr_t'(ctrlCount))
				begin
					sel   = selCtrl;
					index = ctrlOff[4:0];
				end
				else if (txOff < regAddr_t'(txBufBytes))
				begin
					sel   = selTxBuf;
					index = txOff[4:0];
				end
				else if (vbusOff < regAddr_t'(2 * vbusWords) && !vbusOff[0])
				begin
					sel   = selVbusThresh;
					index = {3'b000, vbusOff[2:1]};  // word number
				end
			end
		endcase
	end

	// identity, revision and port status are read only
	always_comb
	begin
		case (sel)
			selVendorId, selProductId, selDeviceId,
			selTypecRev, selPdRev, selPdIfRev,
			selCcStatus, selPowerStatus, selNone: writable = 1'b0;
			default:                              writable = 1'b1;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			decodeValid_o <= 1'b0;
		else
			decodeValid_o <= frontValid_i;
	end

	always_ff @(posedge CLK)
	begin
		if (frontValid_i)
		begin
			decodeReq_o.sel    <= (isWrite && !writable) ? selNone : sel;  // dropped write
			decodeReq_o.index  <= index;
			decodeReq_o.wrEn   <= isWrite && writable;
			decodeReq_o.wrData <= frontReq_i.wrData;
		end
	end

endmodule

// ==== tcpcRegStore.sv ====
module tcpcRegStore import tcpcPkg::*;
#(
	parameter regData_t vendorId  = 16'h0012,
	parameter regData_t productId = 16'hFABC,
	parameter regData_t deviceId  = 16'h0005
)
(
	input  logic        CLK,
	input  logic        reset,
	input  logic        decodeValid_i,
	input  decodedReq_t decodeReq_i,
	input  portStatus_t portStatus_i,
	input  regData_t    alertEvent_i,
	output logic        storeDone_o,
	output regData_t    storeData_o,
	output logic        alert_o
);

	regData_t    alertReg;
	regData_t    alertMask;
	regByte_t    powerStatusMask;
	regByte_t    faultStatusMask;
	regByte_t    faultStatus;
	regByte_t    transmitReg;
	regByte_t    txByteCount;
	regByte_t    ctrlRegs [ctrlCount];
	regByte_t    txBuf [txBufBytes];
	regData_t    vbusRegs [vbusWords];
	portStatus_t portStatus;
	regData_t    alertWritten;
	regData_t    rdWord;
	regByte_t    wrByte;
	logic        hostWrite;

	assign hostWrite = decodeValid_i && decodeReq_i.wrEn;
	assign wrByte    = decodeReq_i.wrData[7:0];  // 8-bit regs take the low byte

	// host write first, hardware events ORed on top
	assign alertWritten = (hostWrite && decodeReq_i.sel == selAlert) ?
		decodeReq_i.wrData : alertReg;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			alertReg        <= '0;
			alertMask       <= alertMaskReset;
			powerStatusMask <= statusMaskReset;
			faultStatusMask <= statusMaskReset;
			faultStatus     <= faultStatusReset;
			transmitReg     <= '0;
			txByteCount     <= txByteCountReset;
			ctrlRegs        <= ctrlReset;
			txBuf           <= txBufReset;
			vbusRegs        <= '{default: '0};
			portStatus      <= '0;
		end
		else
		begin
			alertReg   <= alertWritten | alertEvent_i;
			portStatus <= portStatus_i;  // sampled every cycle
			if (hostWrite)
			begin
				case (decodeReq_i.sel)
					selAlertMask:       alertMask <= decodeReq_i.wrData;
					selPowerStatusMask: powerStatusMask <= wrByte;
					selFaultStatusMask: faultStatusMask <= wrByte;
					selCtrl:            ctrlRegs[decodeReq_i.index[2:0]] <= wrByte;
					selFaultStatus:     faultStatus <= wrByte;
					selTransmit:        transmitReg <= wrByte;
					selTxByteCount:     txByteCount <= wrByte;
					selTxBuf:           txBuf[decodeReq_i.index] <= wrByte;
					selVbusThresh:      vbusRegs[decodeReq_i.index[1:0]] <= decodeReq_i.wrData;
					default:            ;  // alert handled above
				endcase
			end
		end
	end

	always_comb
	begin
		case (decodeReq_i.sel)
			selVendorId:        rdWord = vendorId;
			selProductId:       rdWord = productId;
			selDeviceId:        rdWord = deviceId;
			selTypecRev:        rdWord = typecRevValue;
			selPdRev:           rdWord = pdRevValue;
			selPdIfRev:         rdWord = pdIfRevValue;
			selAlert:           rdWord = alertReg;
			selAlertMask:       rdWord = alertMask;
			selPowerStatusMask: rdWord = {8'h00, powerStatusMask};
			selFaultStatusMask: rdWord = {8'h00, faultStatusMask};
			selCtrl:            rdWord = {8'h00, ctrlRegs[decodeReq_i.index[2:0]]};
			selCcStatus:        rdWord = {8'h00, portStatus.ccStatus};
			selPowerStatus:     rdWord = {8'h00, portStatus.powerStatus};
			selFaultStatus:     rdWord = {8'h00, faultStatus};
			selTransmit:        rdWord = {8'h00, transmitReg};
			selTxByteCount:     rdWord = {8'h00, txByteCount};
			selTxBuf:           rdWord = {8'h00, txBuf[decodeReq_i.index]};
			selVbusThresh:      rdWord = vbusRegs[decodeReq_i.index[1:0]];
			default:            rdWord = '0;  // unmapped reads as zero
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			storeDone_o <= 1'b0;
		else
			storeDone_o <= decodeValid_i;
	end

	always_ff @(posedge CLK)
	begin
		if (decodeValid_i)
			storeData_o <= decodeReq_i.wrEn ? '0 : rdWord;  // writes return zero
	end

	assign alert_o = |(alertReg & alertMask);

endmodule

// ==== tcpcTop.sv ====
module tcpcTop import tcpcPkg::*;
#(
	parameter regData_t vendorId  = 16'h0012,
	parameter regData_t productId = 16'hFABC,
	parameter regData_t deviceId  = 16'h0005
)
(
	input  logic        CLK,
	input  logic        reset,
	input  logic        req_i,
	input  busReq_t     request_i,
	input  portStatus_t portStatus_i,
	input  regData_t    alertEvent_i,
	output logic        ack_o,
	output regData_t    rdData_o,
	output logic        alert_o
);

	logic        frontValid;
	busReq_t     frontReq;
	logic        decodeValid;
	decodedReq_t decodeReq;
	logic        storeDone;
	regData_t    storeData;

	tcpcBusFront front0 (
		.CLK          (CLK),
		.reset        (reset),
		.req_i        (req_i),
		.request_i    (request_i),
		.storeDone_i  (storeDone),
		.storeData_i  (storeData),
		.ack_o        (ack_o),
		.rdData_o     (rdData_o),
		.frontValid_o (frontValid),
		.frontReq_o   (frontReq)
	);

	tcpcAddrDecode decode0 (
		.CLK           (CLK),
		.reset         (reset),
		.frontValid_i  (frontValid),
		.frontReq_i    (frontReq),
		.decodeValid_o (decodeValid),
		.decodeReq_o   (decodeReq)
	);

	tcpcRegStore #(
		.vendorId  (vendorId),
		.productId (productId),
		.deviceId  (deviceId)
	) store0 (
		.CLK           (CLK),
		.reset         (reset),
		.decodeValid_i (decodeValid),
		.decodeReq_i   (decodeReq),
		.portStatus_i  (portStatus_i),
		.alertEvent_i  (alertEvent_i),
		.storeDone_o   (storeDone),
		.storeData_o   (storeData),
		.alert_o       (alert_o)
	);

endmodule

// ==== tcpcTbTasks.svh ====
`ifndef TCPC_TB_TASKS_SVH
`define TCPC_TB_TASKS_SVH

task automatic checkValue(input string name, input regData_t got, input regData_t exp);
	assert (got === exp)
	else
	begin
		errors++;
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
	end
endtask

// one full four-phase access, called and left on a falling edge
task automatic busAccess(input regAddr_t addr, input regData_t data, input logic isRead,
	input int holdCycles, output regData_t rdData);
	int edges;
	request_i = '{addr: addr, wrData: data, readNotWrite: isRead};
	req_i     = 1'b1;
	edges     = 0;
	while (!ack_o && edges < 20)
	begin
		@(negedge CLK);
		edges++;
	end
	assert (ack_o)
	else
	begin
		errors++;
		$display("no ack_o within 20 cycles for address %h", addr);
	end
	checkValue("edges from req_i to ack_o", regData_t'(edges), 16'd4);  // sampling edge + 3
	rdData = rdData_o;
	repeat (holdCycles) @(negedge CLK);  // host keeps req high
	req_i = 1'b0;
	edges = 0;
	while (ack_o && edges < 20)
	begin
		@(negedge CLK);
		edges++;
	end
	checkValue("edges from req_i low to ack_o low", regData_t'(edges), 16'd1);
endtask

task automatic readCheck(input regAddr_t addr, input regData_t exp);
	regData_t got;
	busAccess(addr, '0, 1'b1, 0, got);
	checkValue($sformatf("rdData_o at %h", addr), got, exp);
endtask

task automatic writeReg(input regAddr_t addr, input regData_t data);
	regData_t got;
	busAccess(addr, data, 1'b0, 0, got);
	checkValue("rdData_o on write", got, 16'h0000);
endtask

// one cycle event on the port side
task automatic pulseEvent(input regData_t bits);
	alertEvent_i = bits;
	@(negedge CLK);
	alertEvent_i = '0;
	@(negedge CLK);
endtask

`endif

// ==== tcpcTb.sv ====
module tcpcTb import tcpcPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic        CLK;
	logic        reset;
	logic        req_i;
	busReq_t     request_i;
	portStatus_t portStatus_i;
	regData_t    alertEvent_i;
	logic        ack_o;
	regData_t    rdData_o;
	logic        alert_o;
	int          errors;
	int          cycles;
	int          seed;
	regData_t    data;
	regData_t    evBit;
	regByte_t    txData [30];

	localparam int cycleLimit = 2 * 5 * 200;  // twice the length of about 200 accesses of 5 cycles

	localparam regAddr_t roRegs [8] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h08, 8'h0A, 8'h1D, 8'h1E};
	localparam regData_t roValues [8] = '{16'h0012, 16'hFABC, 16'h0005, 16'h0016,
		16'h0000, 16'hABCD, 16'h0000, 16'h0000};  // port status held at zero
	localparam regData_t ctrlValues [5] = '{16'h0060, 16'h0000, 16'h000A, 16'h0000, 16'h0060};
	localparam regByte_t txReset [14] = '{8'h63, 8'h38, 8'h67, 8'h37, 8'h32, 8'hFF, 8'hC7,
		8'hA7, 8'hA2, 8'hF9, 8'h54, 8'h35, 8'h46, 8'h67};
	localparam regAddr_t wideRegs [6] = '{8'h10, 8'h12, 8'h72, 8'h74, 8'h76, 8'h78};
	localparam regAddr_t byteRegs [10] = '{8'h14, 8'h15, 8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C,
		8'h1F, 8'h50, 8'h51};
	localparam regAddr_t unmapped [6] = '{8'h0C, 8'h20, 8'h4F, 8'h70, 8'h73, 8'hFF};

	`include "tcpcTbTasks.svh"

	tcpcTop dut0 (
		.CLK          (CLK),
		.reset        (reset),
		.req_i        (req_i),
		.request_i    (request_i),
		.portStatus_i (portStatus_i),
		.alertEvent_i (alertEvent_i),
		.ack_o        (ack_o),
		.rdData_o     (rdData_o),
		.alert_o      (alert_o)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	assert property (@(posedge CLK) disable iff (reset) $rose(ack_o) |-> $past(req_i))
	else
	begin
		errors++;
		$display("ack_o rose at %0t ns without req_i sampled high", $time);
	end

	// host back-pressure
	assert property (@(posedge CLK) disable iff (reset)
		ack_o && req_i |=> ack_o && $stable(rdData_o))
	else
	begin
		errors++;
		$display("ack_o dropped or rdData_o changed at %0t ns while req_i was high", $time);
	end

	assert property (@(posedge CLK) disable iff (reset) ack_o && !req_i |=> !ack_o)
	else
	begin
		errors++;
		$display("ack_o still high at %0t ns after req_i was sampled low", $time);
	end

	initial
	begin
		CLK          = 1'b0;
		reset        = 1'b1;
		req_i        = 1'b0;
		request_i    = '0;
		portStatus_i = '0;
		alertEvent_i = '0;
		errors       = 0;
		cycles       = 0;
		seed         = 8;
		repeat (2) @(negedge CLK);
		reset = 1'b0;

		foreach (roRegs[i])
			readCheck(roRegs[i], roValues[i]);
		readCheck(8'h10, 16'h0000);
		readCheck(8'h12, 16'h0FFF);
		readCheck(8'h14, 16'h00FF);
		readCheck(8'h15, 16'h00FF);
		readCheck(8'h1F, 16'h0080);
		foreach (ctrlValues[i])
			readCheck(regAddr_t'(8'h18 + i), ctrlValues[i]);
		readCheck(8'h51, 16'h0065);
		for (int i = 0; i < 30; i++)
		begin
			if (i < 14)
				readCheck(regAddr_t'(8'h52 + i), {8'h00, txReset[i]});
			else
				readCheck(regAddr_t'(8'h52 + i), 16'h0000);
		end
		for (int i = 0; i < 4; i++)
			readCheck(regAddr_t'(8'h72 + 2 * i), 16'h0000);

		foreach (wideRegs[i])
		begin
			data = regData_t'($random(seed));
			writeReg(wideRegs[i], data);
			readCheck(wideRegs[i], data);
		end
		foreach (byteRegs[i])
		begin
			data = regData_t'($random(seed));
			writeReg(byteRegs[i], data);
			readCheck(byteRegs[i], {8'h00, data[7:0]});  // upper byte dropped
		end
		foreach (roRegs[i])
		begin
			writeReg(roRegs[i], regData_t'($random(seed)));
			readCheck(roRegs[i], roValues[i]);
		end
		writeReg(8'h72, 16'h5A5A);
		foreach (unmapped[i])
		begin
			writeReg(unmapped[i], 16'hFFFF);
			readCheck(unmapped[i], 16'h0000);
		end
		readCheck(8'h72, 16'h5A5A);  // odd neighbour 0x73 left it alone

		foreach (txData[i])
		begin
			txData[i] = regByte_t'($random(seed));
			writeReg(regAddr_t'(8'h52 + i), {8'h00, txData[i]});
		end
		foreach (txData[i])
			readCheck(regAddr_t'(8'h52 + i), {8'h00, txData[i]});

		repeat (3)
		begin
			portStatus_i = 16'($random(seed));
			@(negedge CLK);  // one sample cycle
			readCheck(8'h1D, {8'h00, portStatus_i.ccStatus});
			readCheck(8'h1E, {8'h00, portStatus_i.powerStatus});
		end

		evBit = 16'h0001 << ($random(seed) & 15);
		writeReg(8'h12, evBit);
		writeReg(8'h10, 16'h0000);
		checkValue("alert_o", {15'h0, alert_o}, 16'h0000);
		pulseEvent(evBit);
		checkValue("alert_o", {15'h0, alert_o}, 16'h0001);
		readCheck(8'h10, evBit);
		writeReg(8'h10, 16'h0000);
		checkValue("alert_o", {15'h0, alert_o}, 16'h0000);
		readCheck(8'h10, 16'h0000);
		writeReg(8'h12, ~evBit);  // masked out now
		pulseEvent(evBit);
		checkValue("alert_o", {15'h0, alert_o}, 16'h0000);
		readCheck(8'h10, evBit);

		busAccess(8'h12, '0, 1'b1, 5, data);
		checkValue("rdData_o after long hold", data, ~evBit);
		busAccess(8'h51, 16'h00C3, 1'b0, 3, data);
		checkValue("rdData_o on held write", data, 16'h0000);
		readCheck(8'h51, 16'h00C3);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
tcpcPkg.sv
tcpcBusFront.sv
tcpcAddrDecode.sv
tcpcRegStore.sv
tcpcTop.sv
tcpcTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the register bank testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tcpcTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VtcpcTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
